//--- uart_str_pkg.sv
// string framing constants
// shared by the framer, the deframer and the top level

package uart_str_pkg;

	// string buffer capacity in bytes
	localparam int str_bytes = 137;

	// width of the length ports
	// must hold str_bytes plus two during receive counting
	localparam int len_w = 8;

	// ascii '&', sent twice before and twice after the content
	localparam logic [7:0] delim_char = 8'h26;

	// stop bits sent by the transmitter
	localparam int tx_stop_bits = 2;

	// stop bits checked by the receiver
	localparam int rx_stop_bits = 1;

endpackage

//--- uart_tx.sv
// uart byte transmitter
// start bit, 8 data bits lsb first, then STOP_BITS high bits
// byte_done pulses once the last stop bit has been sent
`timescale 1ns/1ps

module uart_tx #(
	parameter int CLK_FREQ  = 50_000_000,
	parameter int BAUD_RATE = 115_200,
	parameter int STOP_BITS = 2
) (
	input  logic       sys_clk,
	input  logic       sys_rst_n,
	input  logic [7:0] byte_data,
	input  logic       byte_req,
	output logic       tx,
	output logic       byte_done
);

	localparam int CLKS_PER_BIT = CLK_FREQ / BAUD_RATE;
	localparam int FRAME_BITS   = 9 + STOP_BITS;
	localparam int CNT_W        = $clog2(CLKS_PER_BIT) + 1;
	localparam int BIT_W        = $clog2(FRAME_BITS) + 1;

	logic                  busy;
	logic [CNT_W-1:0]      baud_cnt;
	logic [BIT_W-1:0]      bit_cnt;
	logic [FRAME_BITS-1:0] shreg;
	logic                  bit_end;

	assign bit_end = (baud_cnt == CNT_W'(CLKS_PER_BIT - 1));

	// bit timing and byte sequencing
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			busy      <= 1'b0;
			baud_cnt  <= '0;
			bit_cnt   <= '0;
			byte_done <= 1'b0;
		end else begin
			byte_done <= 1'b0;
			if (!busy) begin
				if (byte_req) begin
					busy     <= 1'b1;
					baud_cnt <= '0;
					bit_cnt  <= '0;
				end
			end else if (bit_end) begin
				baud_cnt <= '0;
				if (bit_cnt == BIT_W'(FRAME_BITS - 1)) begin
					busy      <= 1'b0;
					byte_done <= 1'b1;
				end else begin
					bit_cnt <= bit_cnt + 1'b1;
				end
			end else begin
				baud_cnt <= baud_cnt + 1'b1;
			end
		end
	end

	// whole frame loaded at once, shifted out lsb first
	always_ff @(posedge sys_clk) begin
		if (!busy && byte_req)
			shreg <= {{STOP_BITS{1'b1}}, byte_data, 1'b0};
		else if (busy && bit_end)
			shreg <= {1'b1, shreg[FRAME_BITS-1:1]};
	end

	// line idles high between bytes
	assign tx = busy ? shreg[0] : 1'b1;

endmodule

//--- uart_rx.sv
// uart byte receiver
// two-flop synchronizer, start bit re-checked at half a bit,
// data sampled mid-bit, stop bits checked before the byte is released
`timescale 1ns/1ps

module uart_rx #(
	parameter int CLK_FREQ  = 50_000_000,
	parameter int BAUD_RATE = 115_200,
	parameter int STOP_BITS = 1
) (
	input  logic       sys_clk,
	input  logic       sys_rst_n,
	input  logic       rx,
	output logic [7:0] rx_byte,
	output logic       rx_byte_vld,
	output logic       rx_frm_err
);

	localparam int CLKS_PER_BIT = CLK_FREQ / BAUD_RATE;
	localparam int HALF_BIT     = CLKS_PER_BIT / 2;
	localparam int CNT_W        = $clog2(CLKS_PER_BIT) + 1;

	typedef enum logic [1:0] {S_IDLE, S_START, S_DATA, S_STOP} state_t;

	state_t           state;
	logic             rx_meta;
	logic             rx_sync;
	logic             rx_prev;
	logic [CNT_W-1:0] cnt;
	logic [3:0]       bit_cnt;
	logic             stop_ok;
	logic [7:0]       shreg;
	logic             sample;
	logic             last_stop;

	assign sample    = (cnt == CNT_W'(CLKS_PER_BIT - 1));
	assign last_stop = (bit_cnt == 4'(STOP_BITS - 1));

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			rx_meta     <= 1'b1;
			rx_sync     <= 1'b1;
			rx_prev     <= 1'b1;
			state       <= S_IDLE;
			cnt         <= '0;
			bit_cnt     <= '0;
			stop_ok     <= 1'b1;
			rx_byte_vld <= 1'b0;
			rx_frm_err  <= 1'b0;
		end else begin
			rx_meta     <= rx;
			rx_sync     <= rx_meta;
			rx_prev     <= rx_sync;
			rx_byte_vld <= 1'b0;
			rx_frm_err  <= 1'b0;
			case (state)
				S_IDLE: begin
					cnt <= '0;
					// falling edge starts a candidate start bit
					if (rx_prev && !rx_sync)
						state <= S_START;
				end
				S_START: begin
					if (cnt == CNT_W'(HALF_BIT - 1)) begin
						cnt     <= '0;
						bit_cnt <= '0;
						state   <= rx_sync ? S_IDLE : S_DATA;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				S_DATA: begin
					if (sample) begin
						cnt <= '0;
						if (bit_cnt == 4'd7) begin
							bit_cnt <= '0;
							stop_ok <= 1'b1;
							state   <= S_STOP;
						end else begin
							bit_cnt <= bit_cnt + 1'b1;
						end
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				default: begin
					if (sample) begin
						cnt <= '0;
						if (last_stop) begin
							state       <= S_IDLE;
							rx_byte_vld <= stop_ok && rx_sync;
							rx_frm_err  <= !(stop_ok && rx_sync);
						end else begin
							bit_cnt <= bit_cnt + 1'b1;
							stop_ok <= stop_ok & rx_sync;
						end
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
			endcase
		end
	end

	// data bits arrive lsb first
	always_ff @(posedge sys_clk) begin
		if (state == S_DATA && sample)
			shreg <= {rx_sync, shreg[7:1]};
		if (state == S_STOP && sample && last_stop)
			rx_byte <= shreg;
	end

endmodule

//--- frame_tx.sv
// frame transmitter
// sends "&&", the content bytes of the captured buffer, then "&&"
// one byte at a time through the uart byte engine
`timescale 1ns/1ps

module frame_tx (
	input  logic                                   sys_clk,
	input  logic                                   sys_rst_n,
	input  logic [uart_str_pkg::str_bytes*8-1:0]   tx_string,
	input  logic [uart_str_pkg::len_w-1:0]         tx_length,
	input  logic                                   tx_req,
	output logic                                   tx_busy,
	output logic                                   tx_done,
	output logic [7:0]                             byte_data,
	output logic                                   byte_req,
	input  logic                                   byte_done
);

	localparam int LEN_W = uart_str_pkg::len_w;

	// one-hot states
	localparam logic [6:0] S_IDLE    = 7'b000_0001;
	localparam logic [6:0] S_SIGN1   = 7'b000_0010;
	localparam logic [6:0] S_SIGN2   = 7'b000_0100;
	localparam logic [6:0] S_CONTENT = 7'b000_1000;
	localparam logic [6:0] S_SIGN3   = 7'b001_0000;
	localparam logic [6:0] S_SIGN4   = 7'b010_0000;
	localparam logic [6:0] S_FINISH  = 7'b100_0000;

	logic [6:0]                           state;
	logic [LEN_W-1:0]                     cnt;
	logic [LEN_W-1:0]                     len_q;
	logic [uart_str_pkg::str_bytes*8-1:0] buf_q;
	logic                                 accept;
	logic                                 load_content;

	// finish behaves like idle for a new request
	assign tx_busy = !(state == S_IDLE || state == S_FINISH);
	assign tx_done = (state == S_FINISH);
	assign accept  = tx_req && !tx_busy;

	assign load_content = byte_done &&
		((state == S_SIGN2 && len_q != '0) || (state == S_CONTENT && cnt != len_q));

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state    <= S_IDLE;
			cnt      <= '0;
			byte_req <= 1'b0;
		end else begin
			byte_req <= 1'b0;
			case (state)
				S_IDLE, S_FINISH: begin
					state    <= accept ? S_SIGN1 : S_IDLE;
					byte_req <= accept;
				end
				S_SIGN1: begin
					if (byte_done) begin
						state    <= S_SIGN2;
						byte_req <= 1'b1;
					end
				end
				S_SIGN2: begin
					if (byte_done) begin
						byte_req <= 1'b1;
						cnt      <= LEN_W'(1);
						// empty string goes straight to the closing pair
						state    <= (len_q == '0) ? S_SIGN3 : S_CONTENT;
					end
				end
				S_CONTENT: begin
					if (byte_done) begin
						byte_req <= 1'b1;
						if (cnt == len_q)
							state <= S_SIGN3;
						else
							cnt <= cnt + 1'b1;
					end
				end
				S_SIGN3: begin
					if (byte_done) begin
						state    <= S_SIGN4;
						byte_req <= 1'b1;
					end
				end
				S_SIGN4: begin
					if (byte_done)
						state <= S_FINISH;
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	// buffer shifts down one byte per content byte sent
	always_ff @(posedge sys_clk) begin
		if (accept) begin
			buf_q     <= tx_string;
			len_q     <= tx_length;
			byte_data <= uart_str_pkg::delim_char;
		end else if (load_content) begin
			byte_data <= buf_q[7:0];
			buf_q     <= buf_q >> 8;
		end else if (byte_done) begin
			byte_data <= uart_str_pkg::delim_char;
		end
	end

endmodule

//--- frame_rx.sv
// frame receiver
// hunts for "&&", stores content bytes until the closing "&&"
// a lone '&' inside the content is kept together with the byte after it
`timescale 1ns/1ps

module frame_rx (
	input  logic                                   sys_clk,
	input  logic                                   sys_rst_n,
	input  logic [7:0]                             rx_byte,
	input  logic                                   rx_byte_vld,
	input  logic                                   rx_frm_err,
	output logic [uart_str_pkg::str_bytes*8-1:0]   rx_string,
	output logic [uart_str_pkg::len_w-1:0]         rx_length,
	output logic                                   rx_busy,
	output logic                                   rx_done,
	output logic                                   rx_err
);

	localparam int               LEN_W   = uart_str_pkg::len_w;
	localparam logic [LEN_W-1:0] MAX_LEN = LEN_W'(uart_str_pkg::str_bytes);

	typedef enum logic [1:0] {S_HUNT, S_SIGN1, S_CONTENT, S_PEND} state_t;

	state_t                               state;
	logic [LEN_W-1:0]                     cnt;
	logic [uart_str_pkg::str_bytes*8-1:0] work;
	logic                                 is_delim;
	logic                                 room_one;
	logic                                 room_two;
	logic                                 frame_end;

	assign is_delim  = (rx_byte == uart_str_pkg::delim_char);
	assign room_one  = (cnt < MAX_LEN);
	assign room_two  = (cnt < MAX_LEN - 1'b1);
	assign frame_end = rx_byte_vld && is_delim && (state == S_PEND);
	assign rx_busy   = (state == S_CONTENT) || (state == S_PEND);

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state     <= S_HUNT;
			cnt       <= '0;
			rx_length <= '0;
			rx_done   <= 1'b0;
			rx_err    <= 1'b0;
		end else begin
			rx_done <= 1'b0;
			rx_err  <= 1'b0;
			case (state)
				S_HUNT: begin
					if (rx_byte_vld && is_delim)
						state <= S_SIGN1;
				end
				S_SIGN1: begin
					if (rx_frm_err) begin
						state <= S_HUNT;
					end else if (rx_byte_vld) begin
						cnt   <= '0;
						state <= is_delim ? S_CONTENT : S_HUNT;
					end
				end
				S_CONTENT: begin
					if (rx_frm_err) begin
						rx_err <= 1'b1;
						state  <= S_HUNT;
					end else if (rx_byte_vld) begin
						if (is_delim) begin
							state <= S_PEND;
						end else if (!room_one) begin
							// buffer full, drop the frame
							rx_err <= 1'b1;
							state  <= S_HUNT;
						end else begin
							cnt <= cnt + 1'b1;
						end
					end
				end
				default: begin
					if (rx_frm_err) begin
						rx_err <= 1'b1;
						state  <= S_HUNT;
					end else if (rx_byte_vld) begin
						if (is_delim) begin
							rx_done   <= 1'b1;
							rx_length <= cnt;
							state     <= S_HUNT;
						end else if (!room_two) begin
							rx_err <= 1'b1;
							state  <= S_HUNT;
						end else begin
							// pending '&' plus this byte
							cnt   <= cnt + 2'd2;
							state <= S_CONTENT;
						end
					end
				end
			endcase
		end
	end

	// working buffer, published only on a good end
	always_ff @(posedge sys_clk) begin
		if (rx_byte_vld && !is_delim) begin
			if (state == S_CONTENT && room_one)
				work[cnt*8 +: 8] <= rx_byte;
			if (state == S_PEND && room_two) begin
				work[cnt*8 +: 8]     <= uart_str_pkg::delim_char;
				work[cnt*8 + 8 +: 8] <= rx_byte;
			end
		end
		if (frame_end)
			rx_string <= work;
	end

endmodule

//--- uart_control.sv
// uart string transceiver top level
// framer and deframer around the uart byte engines
`timescale 1ns/1ps

module uart_control #(
	parameter int CLK_FREQ  = 50_000_000,
	parameter int BAUD_RATE = 115_200
) (
	input  logic                                   sys_clk,
	input  logic                                   sys_rst_n,
	input  logic [uart_str_pkg::str_bytes*8-1:0]   tx_string,
	input  logic [uart_str_pkg::len_w-1:0]         tx_length,
	input  logic                                   tx_req,
	output logic                                   tx_busy,
	output logic                                   tx_done,
	output logic [uart_str_pkg::str_bytes*8-1:0]   rx_string,
	output logic [uart_str_pkg::len_w-1:0]         rx_length,
	output logic                                   rx_busy,
	output logic                                   rx_done,
	output logic                                   rx_err,
	input  logic                                   uart_rx_port,
	output logic                                   uart_tx_port
);

	// byte level, transmit side
	logic [7:0] byte_data;
	logic       byte_req;
	logic       byte_done;

	// byte level, receive side
	logic [7:0] rx_byte;
	logic       rx_byte_vld;
	logic       rx_frm_err;

	frame_tx frame_tx_inst (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.tx_string (tx_string),
		.tx_length (tx_length),
		.tx_req    (tx_req),
		.tx_busy   (tx_busy),
		.tx_done   (tx_done),
		.byte_data (byte_data),
		.byte_req  (byte_req),
		.byte_done (byte_done)
	);

	uart_tx #(
		.CLK_FREQ  (CLK_FREQ),
		.BAUD_RATE (BAUD_RATE),
		.STOP_BITS (uart_str_pkg::tx_stop_bits)
	) uart_tx_inst (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.byte_data (byte_data),
		.byte_req  (byte_req),
		.tx        (uart_tx_port),
		.byte_done (byte_done)
	);

	uart_rx #(
		.CLK_FREQ  (CLK_FREQ),
		.BAUD_RATE (BAUD_RATE),
		.STOP_BITS (uart_str_pkg::rx_stop_bits)
	) uart_rx_inst (
		.sys_clk     (sys_clk),
		.sys_rst_n   (sys_rst_n),
		.rx          (uart_rx_port),
		.rx_byte     (rx_byte),
		.rx_byte_vld (rx_byte_vld),
		.rx_frm_err  (rx_frm_err)
	);

	frame_rx frame_rx_inst (
		.sys_clk     (sys_clk),
		.sys_rst_n   (sys_rst_n),
		.rx_byte     (rx_byte),
		.rx_byte_vld (rx_byte_vld),
		.rx_frm_err  (rx_frm_err),
		.rx_string   (rx_string),
		.rx_length   (rx_length),
		.rx_busy     (rx_busy),
		.rx_done     (rx_done),
		.rx_err      (rx_err)
	);

endmodule

//--- uart_control_chk.sv
// protocol checker for the uart string transceiver
// done pulses, busy release, idle line level and rx outcome exclusivity
`timescale 1ns/1ps

module uart_control_chk (
	input logic sys_clk,
	input logic sys_rst_n,
	input logic tx_busy,
	input logic tx_done,
	input logic rx_done,
	input logic rx_err,
	input logic uart_tx_port
);

	int tx_pulse_fail  = 0;
	int rx_pulse_fail  = 0;
	int busy_fall_fail = 0;
	int idle_line_fail = 0;
	int outcome_fail   = 0;
	int fail_count;

	assign fail_count = tx_pulse_fail + rx_pulse_fail + busy_fall_fail +
		idle_line_fail + outcome_fail;

	tx_done_single: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		tx_done |=> !tx_done)
		else begin
			$error("tx_done stayed high for more than one cycle");
			tx_pulse_fail++;
		end

	rx_done_single: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		rx_done |=> !rx_done)
		else begin
			$error("rx_done stayed high for more than one cycle");
			rx_pulse_fail++;
		end

	// busy may only drop at the end of a frame
	busy_fall_with_done: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		$fell(tx_busy) |-> tx_done)
		else begin
			$error("tx_busy fell without tx_done");
			busy_fall_fail++;
		end

	line_idle_high: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		!tx_busy |-> uart_tx_port)
		else begin
			$error("uart_tx_port low while the transmitter is idle");
			idle_line_fail++;
		end

	done_err_exclusive: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		!(rx_done && rx_err))
		else begin
			$error("rx_done and rx_err high in the same cycle");
			outcome_fail++;
		end

endmodule

bind uart_control uart_control_chk uart_control_chk_inst (
	.sys_clk      (sys_clk),
	.sys_rst_n    (sys_rst_n),
	.tx_busy      (tx_busy),
	.tx_done      (tx_done),
	.rx_done      (rx_done),
	.rx_err       (rx_err),
	.uart_tx_port (uart_tx_port)
);

//--- tb_uart_control.sv
// testbench for the uart string transceiver
// loopback frames, a busy request, an empty frame and driven-line error cases
`timescale 1ns/1ps

module tb_uart_control;

	localparam int CLK_FREQ     = 125_000_000;
	localparam int BAUD_RATE    = 12_500_000;
	localparam int CLKS_PER_BIT = CLK_FREQ / BAUD_RATE;
	localparam int BYTE_CYCLES  = 11 * CLKS_PER_BIT;
	localparam int STR_BYTES    = uart_str_pkg::str_bytes;
	localparam logic [7:0] AMP  = uart_str_pkg::delim_char;
	// 10 + 4 + 10 + 140 + 10 line bytes outside the random frames
	localparam int FIXED_BYTES  = 174;

	logic                                 sys_clk;
	logic                                 sys_rst_n;
	logic [STR_BYTES*8-1:0]               tx_string;
	logic [uart_str_pkg::len_w-1:0]       tx_length;
	logic                                 tx_req;
	logic                                 tx_busy;
	logic                                 tx_done;
	logic [STR_BYTES*8-1:0]               rx_string;
	logic [uart_str_pkg::len_w-1:0]       rx_length;
	logic                                 rx_busy;
	logic                                 rx_done;
	logic                                 rx_err;
	logic                                 uart_rx_port;
	logic                                 uart_tx_port;
	logic                                 loopback;
	logic                                 drv_line;
	logic                                 rx_busy_q;

	logic [7:0] exp_msg [0:STR_BYTES];
	int         rand_len [0:7];
	int         tx_done_cnt = 0;
	int         rx_done_cnt = 0;
	int         rx_err_cnt = 0;
	int         rx_busy_rise_cnt = 0;
	int         cycle_cnt = 0;
	int         cycle_limit = 0;
	int         exp_tx = 0;
	int         exp_rx = 0;
	int         exp_err = 0;
	int         error_count = 0;
	int         tests_run = 0;
	int         tests_failed = 0;
	int         test_err_start = 0;

	// rx line either loops the transmitter back or follows the driver task
	assign uart_rx_port = loopback ? uart_tx_port : drv_line;

	uart_control #(
		.CLK_FREQ  (CLK_FREQ),
		.BAUD_RATE (BAUD_RATE)
	) uart_control_inst (
		.sys_clk      (sys_clk),
		.sys_rst_n    (sys_rst_n),
		.tx_string    (tx_string),
		.tx_length    (tx_length),
		.tx_req       (tx_req),
		.tx_busy      (tx_busy),
		.tx_done      (tx_done),
		.rx_string    (rx_string),
		.rx_length    (rx_length),
		.rx_busy      (rx_busy),
		.rx_done      (rx_done),
		.rx_err       (rx_err),
		.uart_rx_port (uart_rx_port),
		.uart_tx_port (uart_tx_port)
	);

	initial begin
		sys_clk = 1'b0;
		forever #4 sys_clk = ~sys_clk;
	end

	// pulse counters
	always @(posedge sys_clk) begin
		if (tx_done)
			tx_done_cnt <= tx_done_cnt + 1;
		if (rx_done)
			rx_done_cnt <= rx_done_cnt + 1;
		if (rx_err)
			rx_err_cnt <= rx_err_cnt + 1;
		// every frame past its opening pair raises rx_busy once
		rx_busy_q <= rx_busy;
		if (rx_busy && !rx_busy_q)
			rx_busy_rise_cnt <= rx_busy_rise_cnt + 1;
	end

	always @(posedge sys_clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
			$display("Timeout: the run did not finish within %0d cycles", cycle_limit);
			$display("Simulation failed");
			$finish;
		end
	end

	task automatic compare_val(input string test, input int expected, input int actual);
		assert (expected == actual)
		else begin
			$display("Mismatch in %s: expected %0h, actual %0h", test, expected, actual);
			error_count++;
		end
	endtask

	task automatic finish_test(input string test);
		tests_run++;
		if (error_count != test_err_start) begin
			tests_failed++;
			$display("test %s: FAILED with %0d errors", test, error_count - test_err_start);
		end else begin
			$display("test %s: ok", test);
		end
		test_err_start = error_count;
	endtask

	// called on a falling edge, loads exp_msg and pulses tx_req
	task automatic start_frame(input int len);
		tx_string = '0;
		for (int i = 0; i < len; i++)
			tx_string[8*i +: 8] = exp_msg[i];
		tx_length = len[uart_str_pkg::len_w-1:0];
		tx_req = 1'b1;
		@(negedge sys_clk);
		tx_req = 1'b0;
	endtask

	task automatic wait_counts(input int tx_target, input int rx_target, input int err_target);
		while (tx_done_cnt < tx_target || rx_done_cnt < rx_target || rx_err_cnt < err_target)
			@(negedge sys_clk);
		repeat (4) @(negedge sys_clk);
	endtask

	task automatic check_rx(input string test, input int len);
		compare_val(test, len, rx_length);
		for (int i = 0; i < len; i++)
			compare_val(test, exp_msg[i], rx_string[8*i +: 8]);
	endtask

	task automatic check_counts(input string test);
		compare_val(test, exp_tx, tx_done_cnt);
		compare_val(test, exp_rx, rx_done_cnt);
		compare_val(test, exp_err, rx_err_cnt);
		compare_val(test, exp_rx + exp_err, rx_busy_rise_cnt);
	endtask

	// one line byte with start, 8 data bits lsb first, stop and one idle bit
	task automatic drive_byte(input logic [7:0] b, input logic stop_level);
		drv_line = 1'b0;
		repeat (CLKS_PER_BIT) @(negedge sys_clk);
		for (int i = 0; i < 8; i++) begin
			drv_line = b[i];
			repeat (CLKS_PER_BIT) @(negedge sys_clk);
		end
		drv_line = stop_level;
		repeat (CLKS_PER_BIT) @(negedge sys_clk);
		drv_line = 1'b1;
		repeat (CLKS_PER_BIT) @(negedge sys_clk);
	endtask

	task automatic drive_frame(input int len);
		drive_byte(AMP, 1'b1);
		drive_byte(AMP, 1'b1);
		for (int i = 0; i < len; i++)
			drive_byte(exp_msg[i], 1'b1);
		drive_byte(AMP, 1'b1);
		drive_byte(AMP, 1'b1);
	endtask

	initial begin
		int frame_bytes;
		int b;
		void'($urandom(32'h900f_9d4b));
		sys_rst_n = 1'b0;
		tx_string = '0;
		tx_length = '0;
		tx_req    = 1'b0;
		loopback  = 1'b1;
		drv_line  = 1'b1;
		frame_bytes = FIXED_BYTES;
		for (int f = 0; f < 8; f++) begin
			rand_len[f] = $urandom_range(16, 1);
			frame_bytes += rand_len[f] + 4;
		end
		cycle_limit = frame_bytes * BYTE_CYCLES * 6 / 5;

		repeat (16) @(negedge sys_clk);
		sys_rst_n = 1'b1;
		@(negedge sys_clk);
		compare_val("reset", 0, tx_busy);
		compare_val("reset", 0, tx_done);
		compare_val("reset", 0, rx_busy);
		compare_val("reset", 0, rx_done);
		compare_val("reset", 0, rx_err);
		compare_val("reset", 1, uart_tx_port);
		compare_val("reset", 0, rx_length);
		finish_test("reset");

		for (int f = 0; f < 8; f++) begin
			for (int i = 0; i < rand_len[f]; i++) begin
				b = $urandom_range(255, 0);
				exp_msg[i] = (b == AMP) ? 8'h25 : b[7:0];
			end
			exp_tx++;
			exp_rx++;
			start_frame(rand_len[f]);
			wait_counts(exp_tx, exp_rx, exp_err);
			check_counts("loopback");
			check_rx("loopback", rand_len[f]);
		end
		finish_test("loopback");

		// second request lands while the first frame is on the line
		for (int i = 0; i < 6; i++)
			exp_msg[i] = 8'h61 + i;
		exp_tx++;
		exp_rx++;
		start_frame(6);
		while (!tx_busy)
			@(negedge sys_clk);
		repeat (3) @(negedge sys_clk);
		tx_string = {STR_BYTES{8'h58}};
		tx_length = 9;
		tx_req = 1'b1;
		@(negedge sys_clk);
		tx_req = 1'b0;
		wait_counts(exp_tx, exp_rx, exp_err);
		repeat (2 * BYTE_CYCLES) @(negedge sys_clk);
		compare_val("busy_request", 0, tx_busy);
		check_counts("busy_request");
		check_rx("busy_request", 6);
		finish_test("busy_request");

		exp_tx++;
		exp_rx++;
		start_frame(0);
		wait_counts(exp_tx, exp_rx, exp_err);
		check_counts("empty_frame");
		check_rx("empty_frame", 0);
		finish_test("empty_frame");

		loopback = 1'b0;
		drive_byte(8'h41, 1'b1);
		drive_byte(AMP, 1'b1);
		drive_byte(8'h42, 1'b1);
		exp_msg[0] = 8'h61;
		exp_msg[1] = AMP;
		exp_msg[2] = 8'h62;
		exp_rx++;
		drive_frame(3);
		wait_counts(exp_tx, exp_rx, exp_err);
		check_counts("embedded_amp");
		check_rx("embedded_amp", 3);
		// one byte past capacity and no closing pair
		drive_byte(AMP, 1'b1);
		drive_byte(AMP, 1'b1);
		for (int i = 0; i < STR_BYTES + 1; i++)
			drive_byte(8'h30 + (i % 40), 1'b1);
		exp_err++;
		wait_counts(exp_tx, exp_rx, exp_err);
		check_counts("overflow");
		check_rx("overflow", 3);
		finish_test("embedded_amp_overflow");

		drive_byte(AMP, 1'b1);
		drive_byte(AMP, 1'b1);
		drive_byte(8'h78, 1'b1);
		drive_byte(8'h79, 1'b0);
		exp_err++;
		wait_counts(exp_tx, exp_rx, exp_err);
		check_counts("stop_bit_error");
		exp_msg[0] = 8'h6f;
		exp_msg[1] = 8'h6b;
		exp_rx++;
		drive_frame(2);
		wait_counts(exp_tx, exp_rx, exp_err);
		check_counts("stop_bit_error");
		check_rx("stop_bit_error", 2);
		finish_test("stop_bit_error");

		b = uart_control_inst.uart_control_chk_inst.fail_count;
		$display("tests run %0d, tests failed %0d, check errors %0d, assertion failures %0d",
			tests_run, tests_failed, error_count, b);
		if (tests_failed == 0 && error_count == 0 && b == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

//--- verilog.f
uart_str_pkg.sv
uart_tx.sv
uart_rx.sv
frame_tx.sv
frame_rx.sv
uart_control.sv
uart_control_chk.sv
tb_uart_control.sv

//--- Bender.yml
package:
  name: uart_control

sources:
  - uart_str_pkg.sv
  - uart_tx.sv
  - uart_rx.sv
  - frame_tx.sv
  - frame_rx.sv
  - uart_control.sv
  - target: test
    files:
      - uart_control_chk.sv
      - tb_uart_control.sv
